//--- hw/readout_pkg.sv
package readout_pkg;

  ////////////////////////////////////////////////////////////
  // widths of the readout path
  localparam int burst_w         = 128;  // one memory burst
  localparam int word_w          = 32;   // one link word
  localparam int words_per_burst = burst_w / word_w;  // 4 words per burst

  // fifo sizing
  localparam int burst_fifo_depth = 16;
  localparam int burst_fifo_afull = 12;  // warn memory side at this fill level
  localparam int cmd_fifo_depth   = 4;

  ////////////////////////////////////////////////////////////
  // payload types
  typedef logic [burst_w-1:0] burst_t;
  typedef logic [word_w-1:0]  word_t;

  typedef struct packed {
    logic   last;  // last beat of the fill
    burst_t data;
  } burst_beat_t;

  typedef struct packed {
    logic  last;   // end of frame on the link
    word_t data;
  } word_beat_t;

endpackage

//--- hw/stream_fifo.sv
`timescale 1ns/1ns

// circular buffer with first-word fall-through read side
module stream_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk125,
  input  logic     rst_n,
  input  logic     in_valid,     // write request, dropped when full
  input  payload_t in_beat,
  output logic     in_ready,     // not full
  output logic     out_valid,    // head entry present
  output payload_t out_beat,     // head entry, shown before the pop
  input  logic     out_ready,
  output logic     almost_full   // registered level warning
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];  // storage, no reset needed
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;        // occupancy
  logic             push;
  logic             pop;

  assign in_ready  = (count != cnt_w'(depth));
  assign push      = in_valid && in_ready;   // full fifo ignores the write
  assign out_valid = (count != '0);
  assign pop       = out_valid && out_ready;
  assign out_beat  = mem[rd_ptr];            // fall-through head

  always_ff @(posedge clk125) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers, count and warning flag
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      almost_full <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;     // idle or push and pop together
      endcase
      // one cycle behind the count
      almost_full <= (int'(count) >= readout_pkg::burst_fifo_afull);
    end
  end

endmodule

//--- hw/burst_width_converter.sv
`timescale 1ns/1ns

// splits one burst beat into link words, lowest slice first
module burst_width_converter (
  input  logic                     clk125,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  readout_pkg::burst_beat_t in_beat,
  output logic                     in_ready,
  output logic                     out_valid,
  output readout_pkg::word_beat_t  out_beat,
  input  logic                     out_ready
);

  localparam int idx_w = $clog2(readout_pkg::words_per_burst);
  localparam logic [idx_w-1:0] idx_max = idx_w'(readout_pkg::words_per_burst - 1);

  readout_pkg::burst_beat_t beat;  // held burst, payload only
  logic                     loaded;    // beat register holds data
  logic [idx_w-1:0]         idx;       // word being offered
  logic                     last_word;
  logic                     word_fire;
  logic                     load;

  assign last_word = (idx == idx_max);
  assign word_fire = out_valid && out_ready;
  // take a new beat when empty or while the final word leaves
  assign in_ready  = !loaded || (word_fire && last_word);
  assign load      = in_valid && in_ready;
  assign out_valid = loaded;

  always_comb begin
    out_beat.data = beat.data[idx*readout_pkg::word_w +: readout_pkg::word_w];
    out_beat.last = beat.last && last_word;  // only word 3 of a last beat
  end

  always_ff @(posedge clk125) begin
    if (load) begin
      beat <= in_beat;
    end
  end

  ////////////////////////////////////////////////////////////
  // word index and occupancy
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      loaded <= 1'b0;
      idx    <= '0;
    end else if (load) begin
      loaded <= 1'b1;    // back-to-back beats keep it set
      idx    <= '0;
    end else if (word_fire) begin
      idx <= idx + 1'b1;
      if (last_word) begin
        loaded <= 1'b0;  // released after word 3
      end
    end
  end

endmodule

//--- hw/readout_sequencer.sv
`timescale 1ns/1ns

// picks the link source, never splitting a command frame
module readout_sequencer (
  input  logic clk125,
  input  logic rst_n,
  input  logic start_readout,  // one-cycle request
  input  logic cmd_accept,     // command word taken by the link
  input  logic ddr3_accept,    // memory word taken by the link
  input  logic accept_last,    // last flag of the taken word
  output logic use_ddr3_data,
  output logic readout_busy
);

  logic pending;         // readout requested, not yet switched
  logic frame_open;      // command frame in progress
  logic frame_open_nxt;  // frame state after this cycle's accept

  // a word taken this cycle may open or close the frame
  always_comb begin
    frame_open_nxt = frame_open;
    if (cmd_accept) begin
      frame_open_nxt = !accept_last;
    end
  end

  assign readout_busy = pending || use_ddr3_data;

  ////////////////////////////////////////////////////////////
  // source selection
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      pending       <= 1'b0;
      frame_open    <= 1'b0;
      use_ddr3_data <= 1'b0;
    end else begin
      frame_open <= frame_open_nxt;
      if (start_readout) begin
        pending <= 1'b1;
      end
      if (use_ddr3_data) begin
        if (ddr3_accept && accept_last) begin
          use_ddr3_data <= 1'b0;  // fill done, back to commands
        end
      end else if (pending && !frame_open_nxt) begin
        use_ddr3_data <= 1'b1;    // no frame open, safe to switch
        pending       <= 1'b0;
      end
    end
  end

endmodule

//--- hw/link_tx_mux.sv
`timescale 1ns/1ns

// 2:1 stream mux toward the serial link, with pause
module link_tx_mux (
  input  logic                    clk125,
  input  logic                    rst_n,
  input  logic                    readout_pause,  // async level from master
  input  logic                    use_ddr3_data,  // 1 = memory words
  input  logic                    ddr3_valid,
  input  readout_pkg::word_beat_t ddr3_beat,
  output logic                    ddr3_ready,
  input  logic                    cmd_valid,
  input  readout_pkg::word_beat_t cmd_beat,
  output logic                    cmd_ready,
  output logic                    tx_valid,
  output readout_pkg::word_t      tx_data,
  output logic                    tx_last,
  input  logic                    tx_ready,
  output logic                    ddr3_accept,    // memory word taken
  output logic                    cmd_accept,     // command word taken
  output logic                    accept_last
);

  logic pause_meta;  // first sync stage
  logic pause_sync;  // usable pause level
  logic link_go;     // link takes a word from the selected source

  ////////////////////////////////////////////////////////////
  // two-flop synchronizer for the pause level
  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      pause_meta <= 1'b0;
      pause_sync <= 1'b0;
    end else begin
      pause_meta <= readout_pause;
      pause_sync <= pause_meta;
    end
  end

  ////////////////////////////////////////////////////////////
  // combinational steering
  assign link_go  = tx_ready && !pause_sync;

  // no offer to the link while paused
  assign tx_valid = !pause_sync && (use_ddr3_data ? ddr3_valid : cmd_valid);
  assign tx_data  = use_ddr3_data ? ddr3_beat.data : cmd_beat.data;
  assign tx_last  = use_ddr3_data ? ddr3_beat.last : cmd_beat.last;

  // ready goes only to the active source
  assign ddr3_ready = use_ddr3_data && link_go;
  assign cmd_ready  = !use_ddr3_data && link_go;

  // strobes for the sequencer, pause already folded into ready
  assign ddr3_accept = ddr3_valid && ddr3_ready;
  assign cmd_accept  = cmd_valid && cmd_ready;
  assign accept_last = tx_last;  // meaningful with either strobe

endmodule

//--- hw/channel_readout.sv
`timescale 1ns/1ns

// readout path from memory bursts to the serial link
module channel_readout (
  input  logic                clk125,
  input  logic                rst_n,
  // memory side
  input  logic                burst_valid,
  input  readout_pkg::burst_t burst_data,
  input  logic                burst_last,    // last beat of the fill
  output logic                burst_afull,   // memory side must stop
  // command side
  input  logic                cmd_valid,
  input  readout_pkg::word_t  cmd_data,
  input  logic                cmd_last,
  output logic                cmd_ready,
  // control
  input  logic                start_readout,
  input  logic                readout_pause,
  output logic                readout_busy,
  // link side
  output logic                tx_valid,
  output readout_pkg::word_t  tx_data,
  output logic                tx_last,
  input  logic                tx_ready
);

  readout_pkg::burst_beat_t burst_in_beat;
  readout_pkg::burst_beat_t burst_head;       // fifo head to converter
  readout_pkg::word_beat_t  cmd_in_beat;
  readout_pkg::word_beat_t  cmd_head;         // fifo head to mux
  readout_pkg::word_beat_t  ddr3_word;        // converter output
  logic                     burst_head_valid;
  logic                     burst_head_ready;
  logic                     cmd_head_valid;
  logic                     cmd_head_ready;
  logic                     ddr3_word_valid;
  logic                     ddr3_word_ready;
  logic                     use_ddr3_data;
  logic                     ddr3_accept;
  logic                     cmd_accept;
  logic                     accept_last;

  assign burst_in_beat = '{last: burst_last, data: burst_data};
  assign cmd_in_beat   = '{last: cmd_last, data: cmd_data};

  ////////////////////////////////////////////////////////////
  // input buffering
  stream_fifo #(
    .payload_t (readout_pkg::burst_beat_t),
    .depth     (readout_pkg::burst_fifo_depth)
  ) u_burst_fifo (
    .clk125(clk125), .rst_n(rst_n),
    .in_valid(burst_valid), .in_beat(burst_in_beat), .in_ready(),  // overflow dropped
    .out_valid(burst_head_valid), .out_beat(burst_head), .out_ready(burst_head_ready),
    .almost_full(burst_afull)
  );

  stream_fifo #(
    .payload_t (readout_pkg::word_beat_t),
    .depth     (readout_pkg::cmd_fifo_depth)
  ) u_cmd_fifo (
    .clk125(clk125), .rst_n(rst_n),
    .in_valid(cmd_valid), .in_beat(cmd_in_beat), .in_ready(cmd_ready),
    .out_valid(cmd_head_valid), .out_beat(cmd_head), .out_ready(cmd_head_ready),
    .almost_full()
  );

  ////////////////////////////////////////////////////////////
  // 128 to 32 bit split, source control and link mux
  burst_width_converter u_width_conv (
    .clk125(clk125), .rst_n(rst_n),
    .in_valid(burst_head_valid), .in_beat(burst_head), .in_ready(burst_head_ready),
    .out_valid(ddr3_word_valid), .out_beat(ddr3_word), .out_ready(ddr3_word_ready)
  );

  readout_sequencer u_sequencer (
    .clk125(clk125), .rst_n(rst_n), .start_readout(start_readout),
    .cmd_accept(cmd_accept), .ddr3_accept(ddr3_accept), .accept_last(accept_last),
    .use_ddr3_data(use_ddr3_data), .readout_busy(readout_busy)
  );

  link_tx_mux u_link_mux (
    .clk125(clk125), .rst_n(rst_n), .readout_pause(readout_pause),
    .use_ddr3_data(use_ddr3_data),
    .ddr3_valid(ddr3_word_valid), .ddr3_beat(ddr3_word), .ddr3_ready(ddr3_word_ready),
    .cmd_valid(cmd_head_valid), .cmd_beat(cmd_head), .cmd_ready(cmd_head_ready),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last), .tx_ready(tx_ready),
    .ddr3_accept(ddr3_accept), .cmd_accept(cmd_accept), .accept_last(accept_last)
  );

endmodule

//--- sim/channel_readout_props.sv
`timescale 1ns/1ns

// link protocol and warning flag rules on the readout top
module channel_readout_props (
  input logic                     clk125,
  input logic                     rst_n,
  input logic                     tx_valid,
  input logic                     tx_ready,
  input readout_pkg::word_t       tx_data,
  input logic                     tx_last,
  input logic                     readout_pause,  // raw pause level at the top
  input logic                     burst_afull,
  input logic [4:0]               burst_count   // burst fifo occupancy
);

  // held word stays put until taken
  a_tx_stable: assert property (@(posedge clk125) disable iff (!rst_n)
    tx_valid && !tx_ready |=> !tx_valid || ($stable(tx_data) && $stable(tx_last)))
    else $error("tx word changed under back-pressure");

  // pause reaches the link two cycles late through the synchronizer
  a_pause_quiet: assert property (@(posedge clk125) disable iff (!rst_n)
    $past(readout_pause, 2) && $past(readout_pause, 3) |-> !tx_valid)
    else $error("tx_valid during pause");

  a_reset_quiet: assert property (@(posedge clk125) $rose(rst_n) |-> !tx_valid)
    else $error("tx_valid right after reset");

  // registered flag only drops once the count is back at the threshold or below
  a_afull_hold: assert property (@(posedge clk125) disable iff (!rst_n)
    $fell(burst_afull) |-> burst_count <= readout_pkg::burst_fifo_afull)
    else $error("burst_afull fell above threshold");

endmodule

bind channel_readout channel_readout_props u_props (
  .clk125(clk125), .rst_n(rst_n),
  .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data), .tx_last(tx_last),
  .readout_pause(readout_pause),
  .burst_afull(burst_afull), .burst_count(u_burst_fifo.count)
);

//--- sim/channel_readout_tb.sv
`timescale 1ns/1ns

module channel_readout_tb;

  localparam int total_words = 128;  // words sent over all tests
  localparam longint limit_ns = (200 * total_words + 2000) * 10;

  logic                clk125 = 1'b0;
  logic                rst_n;
  logic                burst_valid;
  readout_pkg::burst_t burst_data;
  logic                burst_last;
  logic                burst_afull;
  logic                cmd_valid;
  readout_pkg::word_t  cmd_data;
  logic                cmd_last;
  logic                cmd_ready;
  logic                start_readout;
  logic                readout_pause;
  logic                readout_busy;
  logic                tx_valid;
  readout_pkg::word_t  tx_data;
  logic                tx_last;
  logic                tx_ready;

  readout_pkg::word_t exp_data[$];  // expected link words in order
  logic               exp_last[$];
  logic               rand_ready = 1'b0;  // random back-pressure on
  integer             seed = 10;
  int                 data_errs = 0;
  int                 flag_errs = 0;
  int                 other_errs = 0;

  channel_readout dut (.*);

  always #5 clk125 = ~clk125;

  ////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_word(input string name, input readout_pkg::word_t got,
                            input readout_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      flag_errs++;
    end
  endtask

  function automatic readout_pkg::word_t word_at(int base, int beat, int idx);
    return {base[15:0], beat[7:0], idx[7:0]};  // traceable pattern
  endfunction

  ////////////////////////////////////////////////////////////
  // link monitor, sampled mid-cycle where everything is settled
  always @(negedge clk125) begin
    if (rst_n && tx_valid && tx_ready) begin
      if (exp_data.size() == 0) begin
        $display("unexpected word %h on the link at %0t", tx_data, $time);
        other_errs++;
      end else begin
        check_word("tx_data", tx_data, exp_data.pop_front());
        check_flag("tx_last", tx_last, exp_last.pop_front());
      end
    end
  end

  always @(posedge clk125) begin
    tx_ready <= rand_ready ? 1'($random(seed)) : 1'b1;  // stall some cycles
  end

  ////////////////////////////////////////////////////////////
  // drivers
  task automatic send_cmd_frame(input int n, input int base);
    for (int i = 0; i < n; i++) begin
      @(posedge clk125);
      cmd_valid <= 1'b1;
      cmd_data  <= word_at(base, 255, i);
      cmd_last  <= (i == n - 1);
      exp_data.push_back(word_at(base, 255, i));
      exp_last.push_back(i == n - 1);
      @(negedge clk125);
      while (!cmd_ready) @(negedge clk125);  // word moves at the next edge
    end
    @(posedge clk125);
    cmd_valid <= 1'b0;
  endtask

  task automatic write_bursts(input int k, input int base);
    for (int b = 0; b < k; b++) begin
      @(posedge clk125);
      burst_valid <= 1'b1;
      burst_data  <= {word_at(base, b, 3), word_at(base, b, 2),
                      word_at(base, b, 1), word_at(base, b, 0)};
      burst_last  <= (b == k - 1);
    end
    @(posedge clk125);
    burst_valid <= 1'b0;
  endtask

  task automatic queue_burst_words(input int k, input int base);
    for (int b = 0; b < k; b++) begin
      for (int i = 0; i < 4; i++) begin
        exp_data.push_back(word_at(base, b, i));  // lowest slice first
        exp_last.push_back(b == k - 1 && i == 3);
      end
    end
  endtask

  task automatic pulse_start();
    @(posedge clk125);
    start_readout <= 1'b1;
    @(posedge clk125);
    start_readout <= 1'b0;
  endtask

  task automatic wait_drained();
    @(negedge clk125);
    while (exp_data.size() != 0 || readout_busy) @(negedge clk125);
    repeat (2) @(negedge clk125);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_cmd_frames();
    send_cmd_frame(3, 16'h0100);
    send_cmd_frame(4, 16'h0101);
    send_cmd_frame(5, 16'h0102);
    wait_drained();
  endtask

  task automatic test_fill_readout();
    int k;
    for (int r = 0; r < 2; r++) begin
      k = (r == 0) ? 1 : 3;
      write_bursts(k, 16'h0200 + r);
      queue_burst_words(k, 16'h0200 + r);
      pulse_start();
      @(negedge clk125);
      check_flag("readout_busy", readout_busy, 1'b1);
      while (exp_data.size() != 0) @(negedge clk125);  // last word seen on the link
      @(negedge clk125);
      check_flag("readout_busy", readout_busy, 1'b0);  // drops once the last word is taken
      wait_drained();
    end
    send_cmd_frame(3, 16'h0210);  // commands pass again
    wait_drained();
  endtask

  task automatic test_frame_order();
    write_bursts(2, 16'h0300);
    fork
      send_cmd_frame(5, 16'h0301);
      begin
        repeat (2) begin
          @(negedge clk125);
          while (!(cmd_valid && cmd_ready)) @(negedge clk125);
        end
        pulse_start();  // frame is open here
      end
    join
    queue_burst_words(2, 16'h0300);  // only after the whole frame
    wait_drained();
  endtask

  task automatic test_pause();
    @(posedge clk125);
    readout_pause <= 1'b1;
    repeat (3) @(posedge clk125);
    write_bursts(2, 16'h0400);
    queue_burst_words(2, 16'h0400);
    pulse_start();
    repeat (20) begin
      @(negedge clk125);
      check_flag("tx_valid", tx_valid, 1'b0);
    end
    @(posedge clk125);
    readout_pause <= 1'b0;
    wait_drained();
  endtask

  task automatic test_backpressure();
    rand_ready = 1'b1;
    write_bursts(6, 16'h0500);
    queue_burst_words(6, 16'h0500);
    pulse_start();
    wait_drained();
    rand_ready = 1'b0;
  endtask

  task automatic test_almost_full();
    write_bursts(13, 16'h0600);  // converter holds one beat, 12 stay in the fifo
    repeat (2) @(negedge clk125);
    check_flag("burst_afull", burst_afull, 1'b1);
    queue_burst_words(13, 16'h0600);
    pulse_start();
    wait_drained();
    check_flag("burst_afull", burst_afull, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  initial begin
    rst_n = 1'b0;
    burst_valid = 1'b0;
    burst_data = '0;
    burst_last = 1'b0;
    cmd_valid = 1'b0;
    cmd_data = '0;
    cmd_last = 1'b0;
    start_readout = 1'b0;
    readout_pause = 1'b0;
    tx_ready = 1'b0;
    repeat (4) @(posedge clk125);
    rst_n <= 1'b1;
    test_cmd_frames();
    test_fill_readout();
    test_frame_order();
    test_pause();
    test_backpressure();
    test_almost_full();
    $display("errors %0d: data %0d, flag %0d, other %0d",
             data_errs + flag_errs + other_errs, data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(limit_ns);
    $display("timeout, the tests did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- build.f
hw/readout_pkg.sv
hw/stream_fifo.sv
hw/burst_width_converter.sv
hw/readout_sequencer.sv
hw/link_tx_mux.sv
hw/channel_readout.sv
sim/channel_readout_props.sv
sim/channel_readout_tb.sv

//--- Makefile
TOP = channel_readout_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
